//--- src/soc_pkg.sv
/*
 * soc_pkg
 * address map, bus widths, bus request and response structs,
 * and the state and target encodings shared by the memory side
 */
package soc_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// memory sizes in words, as powers of two
	localparam int MAIN_DEPTH_LOG2 = 10;
	localparam int SCRATCH_DEPTH_LOG2 = 8;

	// address map
	localparam int MMIO_BIT = 31;
	localparam logic [ADDR_W-1:0] SCRATCH_BASE = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h8000_2000;
	localparam logic [ADDR_W-1:0] LOADER_BASE = 32'h8000_3000;
	// 4 KiB regions inside io space
	localparam logic [ADDR_W-1:0] REGION_MASK = 32'hFFFF_F000;

	localparam int LED_W = 4;
	localparam int SW_W = 2;
	localparam int BTN_W = 2;
	localparam int COUNT_W = 16;

	typedef logic [DATA_W-1:0] bus_word_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		bus_word_t wdata;
		logic we;
		logic rd;
	} bus_req_t;

	typedef struct packed {
		bus_word_t rdata;
		logic ready;
	} bus_rsp_t;

	typedef logic [LED_W-1:0] led_t;

	typedef struct packed {
		logic overrun;
		logic done;
		logic [13:0] spare;
		logic [COUNT_W-1:0] count;
	} loader_status_t;

	typedef enum logic [2:0] {TGT_MAIN, TGT_SCRATCH, TGT_GPIO, TGT_LOADER, TGT_NONE} target_e;
	typedef enum logic [1:0] {OWN_IDLE, OWN_CPU, OWN_LOADER} owner_e;
	typedef enum logic [1:0] {LD_COUNT, LD_DATA, LD_DONE} loader_state_e;

endpackage

//--- src/word_ram.sv
/*
 * word_ram
 * single-port word memory, registered read,
 * ready pulses the cycle after each strobe
 */
module word_ram #(
	parameter int DEPTH_LOG2 = 10
) (
	input logic clk_mem,
	input logic rst_n,
	input soc_pkg::bus_req_t req,
	output soc_pkg::bus_rsp_t rsp
);

	soc_pkg::bus_word_t mem [2**DEPTH_LOG2];
	soc_pkg::bus_word_t rdata;
	logic ready;
	logic [DEPTH_LOG2-1:0] idx;

	// word index, byte offset dropped
	assign idx = req.addr[DEPTH_LOG2+1:2];

	always_ff @(posedge clk_mem) begin
		if (req.we)
			mem[idx] <= req.wdata;
		if (req.rd)
			rdata <= mem[idx];
	end

	always_ff @(posedge clk_mem) begin
		if (!rst_n)
			ready <= 1'b0;
		else
			ready <= req.we | req.rd;
	end

	assign rsp = '{rdata: rdata, ready: ready};

	a_no_rd_we: assert property (@(posedge clk_mem) disable iff (!rst_n)
		!(req.we && req.rd));

endmodule

//--- src/bus_arbiter.sv
/*
 * bus_arbiter
 * two-host arbiter where the processor port wins ties
 * and the owner keeps the bus until it drops req
 */
module bus_arbiter (
	input logic clk_mem,
	input logic rst_n,
	input logic cpu_req_on,
	output logic cpu_gnt,
	input soc_pkg::bus_req_t cpu_bus,
	output soc_pkg::bus_rsp_t cpu_rsp,
	input logic ld_req_on,
	output logic ld_gnt,
	input soc_pkg::bus_req_t ld_bus,
	output soc_pkg::bus_rsp_t ld_rsp,
	output soc_pkg::bus_req_t bus,
	input soc_pkg::bus_rsp_t rsp
);

	soc_pkg::owner_e owner;

	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			owner <= soc_pkg::OWN_IDLE;
		end else begin
			case (owner)
				soc_pkg::OWN_IDLE: begin
					if (cpu_req_on)
						owner <= soc_pkg::OWN_CPU;
					else if (ld_req_on)
						owner <= soc_pkg::OWN_LOADER;
				end
				soc_pkg::OWN_CPU: begin
					if (!cpu_req_on)
						owner <= soc_pkg::OWN_IDLE;
				end
				soc_pkg::OWN_LOADER: begin
					if (!ld_req_on)
						owner <= soc_pkg::OWN_IDLE;
				end
				default: owner <= soc_pkg::OWN_IDLE;
			endcase
		end
	end

	assign cpu_gnt = owner == soc_pkg::OWN_CPU;
	assign ld_gnt = owner == soc_pkg::OWN_LOADER;

	// only the owner's request reaches the decoder
	always_comb begin
		case (owner)
			soc_pkg::OWN_CPU: bus = cpu_bus;
			soc_pkg::OWN_LOADER: bus = ld_bus;
			default: bus = '0;
		endcase
	end

	// ready is steered to the owner alone
	always_comb begin
		cpu_rsp = rsp;
		ld_rsp = rsp;
		cpu_rsp.ready = rsp.ready & cpu_gnt;
		ld_rsp.ready = rsp.ready & ld_gnt;
	end

	// a host keeps the bus until its ready has arrived
	a_ready_to_owner: assert property (@(posedge clk_mem) disable iff (!rst_n)
		rsp.ready |-> (cpu_gnt || ld_gnt));

endmodule

//--- src/serial_loader.sv
/*
 * serial_loader
 * builds a word count and data words from received bytes,
 * writes word k to main memory at 4*k as bus host 1
 */
module serial_loader (
	input logic clk_mem,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_new,
	output logic req_on,
	input logic gnt,
	output soc_pkg::bus_req_t bus,
	input soc_pkg::bus_rsp_t rsp,
	output soc_pkg::loader_status_t status
);

	soc_pkg::loader_state_e state;
	logic [1:0] byte_idx;
	soc_pkg::bus_word_t shifter;
	soc_pkg::bus_word_t word;
	logic word_done;
	logic [soc_pkg::COUNT_W-1:0] total;
	logic [soc_pkg::COUNT_W-1:0] rx_words;
	logic [soc_pkg::COUNT_W-1:0] written;
	logic pend_valid;
	logic issued;
	soc_pkg::bus_word_t pend_data;
	logic [soc_pkg::ADDR_W-1:0] pend_addr;
	logic overrun;

	// lsb first, so each new byte enters at the top
	assign word = {rx_data, shifter[31:8]};
	assign word_done = rx_new && byte_idx == 2'd3 && state != soc_pkg::LD_DONE;

	always_ff @(posedge clk_mem) begin
		if (rx_new)
			shifter <= word;
		if (word_done && state == soc_pkg::LD_DATA && !pend_valid) begin
			pend_data <= word;
			pend_addr <= {{(soc_pkg::ADDR_W-soc_pkg::COUNT_W-2){1'b0}}, rx_words, 2'b00};
		end
	end

	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			state <= soc_pkg::LD_COUNT;
			byte_idx <= '0;
			total <= '0;
			rx_words <= '0;
			written <= '0;
			pend_valid <= 1'b0;
			issued <= 1'b0;
			overrun <= 1'b0;
		end else begin
			if (rx_new && state != soc_pkg::LD_DONE)
				byte_idx <= byte_idx + 2'd1;
			if (word_done && state == soc_pkg::LD_COUNT) begin
				total <= word[soc_pkg::COUNT_W-1:0];
				state <= word[soc_pkg::COUNT_W-1:0] == '0 ? soc_pkg::LD_DONE : soc_pkg::LD_DATA;
			end
			if (word_done && state == soc_pkg::LD_DATA) begin
				rx_words <= rx_words + 1'b1;
				if (rx_words + 1'b1 == total)
					state <= soc_pkg::LD_DONE;
				// one word of buffering, a second one is lost
				if (pend_valid)
					overrun <= 1'b1;
				else
					pend_valid <= 1'b1;
			end
			if (bus.we)
				issued <= 1'b1;
			if (issued && rsp.ready) begin
				issued <= 1'b0;
				pend_valid <= 1'b0;
				written <= written + 1'b1;
			end
		end
	end

	assign req_on = pend_valid;

	always_comb begin
		bus.addr = pend_addr;
		bus.wdata = pend_data;
		bus.we = gnt && pend_valid && !issued;
		bus.rd = 1'b0;
	end

	assign status = '{overrun: overrun, done: state == soc_pkg::LD_DONE && !pend_valid,
		spare: '0, count: written};

endmodule

//--- src/address_decoder.sv
/*
 * address_decoder
 * selects main memory, scratch ram, gpio or loader status,
 * gates strobes to one target and returns its response
 */
module address_decoder (
	input logic clk_mem,
	input logic rst_n,
	input soc_pkg::bus_req_t bus,
	output soc_pkg::bus_rsp_t rsp,
	output soc_pkg::bus_req_t main_req,
	input soc_pkg::bus_rsp_t main_rsp,
	output soc_pkg::bus_req_t scratch_req,
	input soc_pkg::bus_rsp_t scratch_rsp,
	output soc_pkg::bus_req_t gpio_req,
	input soc_pkg::bus_rsp_t gpio_rsp,
	input soc_pkg::loader_status_t loader_status
);

	soc_pkg::target_e tgt;
	soc_pkg::target_e sel_tgt;
	logic strobe;
	logic local_ready;
	soc_pkg::bus_word_t local_rdata;

	always_comb begin
		if (!bus.addr[soc_pkg::MMIO_BIT])
			tgt = soc_pkg::TGT_MAIN;
		else if ((bus.addr & soc_pkg::REGION_MASK) == soc_pkg::SCRATCH_BASE)
			tgt = soc_pkg::TGT_SCRATCH;
		else if ((bus.addr & soc_pkg::REGION_MASK) == soc_pkg::GPIO_BASE)
			tgt = soc_pkg::TGT_GPIO;
		else if ((bus.addr & soc_pkg::REGION_MASK) == soc_pkg::LOADER_BASE)
			tgt = soc_pkg::TGT_LOADER;
		else
			tgt = soc_pkg::TGT_NONE;
	end

	assign strobe = bus.we | bus.rd;

	always_comb begin
		main_req = bus;
		scratch_req = bus;
		gpio_req = bus;
		main_req.we = bus.we && tgt == soc_pkg::TGT_MAIN;
		main_req.rd = bus.rd && tgt == soc_pkg::TGT_MAIN;
		scratch_req.we = bus.we && tgt == soc_pkg::TGT_SCRATCH;
		scratch_req.rd = bus.rd && tgt == soc_pkg::TGT_SCRATCH;
		gpio_req.we = bus.we && tgt == soc_pkg::TGT_GPIO;
		gpio_req.rd = bus.rd && tgt == soc_pkg::TGT_GPIO;
	end

	// loader status and unmapped space answered here
	always_ff @(posedge clk_mem) begin
		if (bus.rd && tgt == soc_pkg::TGT_LOADER)
			local_rdata <= loader_status;
		else
			local_rdata <= '0;
	end

	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			sel_tgt <= soc_pkg::TGT_NONE;
			local_ready <= 1'b0;
		end else begin
			if (strobe)
				sel_tgt <= tgt;
			local_ready <= strobe && (tgt == soc_pkg::TGT_LOADER || tgt == soc_pkg::TGT_NONE);
		end
	end

	always_comb begin
		case (sel_tgt)
			soc_pkg::TGT_MAIN: rsp = main_rsp;
			soc_pkg::TGT_SCRATCH: rsp = scratch_rsp;
			soc_pkg::TGT_GPIO: rsp = gpio_rsp;
			default: rsp = '{rdata: local_rdata, ready: local_ready};
		endcase
	end

	// every target must answer one cycle after its strobe
	a_ready_follows: assert property (@(posedge clk_mem) disable iff (!rst_n)
		strobe |=> rsp.ready);

endmodule

//--- src/gpio_port.sv
/*
 * gpio_port
 * led register at offset 0, synchronized switches and buttons at offset 4
 */
module gpio_port (
	input logic clk_mem,
	input logic rst_n,
	input soc_pkg::bus_req_t req,
	output soc_pkg::bus_rsp_t rsp,
	input logic [soc_pkg::SW_W-1:0] sw,
	input logic [soc_pkg::BTN_W-1:0] btn,
	output soc_pkg::led_t led
);

	logic [soc_pkg::SW_W+soc_pkg::BTN_W-1:0] in_meta;
	logic [soc_pkg::SW_W+soc_pkg::BTN_W-1:0] in_sync;
	soc_pkg::led_t led_reg;
	soc_pkg::bus_word_t rdata;
	logic ready;

	// two-flop synchronizer, switches above buttons
	always_ff @(posedge clk_mem) begin
		if (!rst_n) begin
			in_meta <= '0;
			in_sync <= '0;
			led_reg <= '0;
			ready <= 1'b0;
		end else begin
			in_meta <= {sw, btn};
			in_sync <= in_meta;
			ready <= req.we | req.rd;
			if (req.we && req.addr[3:2] == 2'd0)
				led_reg <= req.wdata[soc_pkg::LED_W-1:0];
		end
	end

	always_ff @(posedge clk_mem) begin
		if (req.rd) begin
			case (req.addr[3:2])
				2'd0: rdata <= soc_pkg::bus_word_t'(led_reg);
				2'd1: rdata <= soc_pkg::bus_word_t'(in_sync);
				default: rdata <= '0;
			endcase
		end
	end

	assign rsp = '{rdata: rdata, ready: ready};
	assign led = led_reg;

endmodule

//--- src/soc_top.sv
/*
 * soc_top
 * memory side of the soc, arbiter, serial loader, address decoder,
 * main memory, scratch ram and gpio on one clock
 */
module soc_top (
	input logic clk_mem,
	input logic rst_n,
	input logic cpu_req_on,
	output logic cpu_gnt,
	input soc_pkg::bus_req_t cpu_bus,
	output soc_pkg::bus_rsp_t cpu_rsp,
	input logic [7:0] rx_data,
	input logic rx_new,
	input logic [soc_pkg::SW_W-1:0] sw,
	input logic [soc_pkg::BTN_W-1:0] btn,
	output soc_pkg::led_t led
);

	// loader host
	logic ld_req_on;
	logic ld_gnt;
	soc_pkg::bus_req_t ld_bus;
	soc_pkg::bus_rsp_t ld_rsp;
	soc_pkg::loader_status_t loader_status;

	// shared bus after arbitration
	soc_pkg::bus_req_t arb_bus;
	soc_pkg::bus_rsp_t arb_rsp;

	// targets
	soc_pkg::bus_req_t main_req;
	soc_pkg::bus_rsp_t main_rsp;
	soc_pkg::bus_req_t scratch_req;
	soc_pkg::bus_rsp_t scratch_rsp;
	soc_pkg::bus_req_t gpio_req;
	soc_pkg::bus_rsp_t gpio_rsp;

	bus_arbiter arb_inst (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.cpu_req_on(cpu_req_on),
		.cpu_gnt(cpu_gnt),
		.cpu_bus(cpu_bus),
		.cpu_rsp(cpu_rsp),
		.ld_req_on(ld_req_on),
		.ld_gnt(ld_gnt),
		.ld_bus(ld_bus),
		.ld_rsp(ld_rsp),
		.bus(arb_bus),
		.rsp(arb_rsp)
	);

	serial_loader loader_inst (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_new(rx_new),
		.req_on(ld_req_on),
		.gnt(ld_gnt),
		.bus(ld_bus),
		.rsp(ld_rsp),
		.status(loader_status)
	);

	address_decoder decoder_inst (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.bus(arb_bus),
		.rsp(arb_rsp),
		.main_req(main_req),
		.main_rsp(main_rsp),
		.scratch_req(scratch_req),
		.scratch_rsp(scratch_rsp),
		.gpio_req(gpio_req),
		.gpio_rsp(gpio_rsp),
		.loader_status(loader_status)
	);

	word_ram #(.DEPTH_LOG2(soc_pkg::MAIN_DEPTH_LOG2)) main_ram (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.req(main_req),
		.rsp(main_rsp)
	);

	word_ram #(.DEPTH_LOG2(soc_pkg::SCRATCH_DEPTH_LOG2)) scratch_ram (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.req(scratch_req),
		.rsp(scratch_rsp)
	);

	gpio_port gpio_inst (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.req(gpio_req),
		.rsp(gpio_rsp),
		.sw(sw),
		.btn(btn),
		.led(led)
	);

endmodule

//--- tb/tb_soc.sv
/*
 * tb_soc
 * self-checking testbench for the soc memory side that checks processor port
 * accesses, serial loading and loader back-pressure against a reference model
 */
module tb_soc;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	// serial loads dominate at about 12 cycles per byte
	localparam int TIMEOUT_CYCLES = 30000;
	localparam int LOAD_WORDS = 6;
	localparam logic [31:0] UNMAPPED_ADDR = 32'h8000_7000;

	logic clk_mem;
	logic rst_n;
	logic cpu_req_on;
	logic cpu_gnt;
	soc_pkg::bus_req_t cpu_bus;
	soc_pkg::bus_rsp_t cpu_rsp;
	logic [7:0] rx_data;
	logic rx_new;
	logic [soc_pkg::SW_W-1:0] sw;
	logic [soc_pkg::BTN_W-1:0] btn;
	soc_pkg::led_t led;

	// reference model state
	soc_pkg::bus_word_t main_model [2**soc_pkg::MAIN_DEPTH_LOG2];
	soc_pkg::bus_word_t scratch_model [2**soc_pkg::SCRATCH_DEPTH_LOG2];
	soc_pkg::led_t led_model;
	logic [soc_pkg::SW_W-1:0] sw_model;
	logic [soc_pkg::BTN_W-1:0] btn_model;
	soc_pkg::loader_status_t status_model;

	integer seed;
	string test_name;

	// outstanding processor port access
	logic pend_active;
	logic pend_read;
	logic pend_check;
	logic [31:0] pend_addr;
	soc_pkg::bus_word_t pend_exp;

	soc_top UUT (
		.clk_mem(clk_mem),
		.rst_n(rst_n),
		.cpu_req_on(cpu_req_on),
		.cpu_gnt(cpu_gnt),
		.cpu_bus(cpu_bus),
		.cpu_rsp(cpu_rsp),
		.rx_data(rx_data),
		.rx_new(rx_new),
		.sw(sw),
		.btn(btn),
		.led(led)
	);

	initial begin
		clk_mem = 1'b0;
		forever #(CLK_PERIOD / 2) clk_mem = ~clk_mem;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input soc_pkg::bus_word_t exp,
		input soc_pkg::bus_word_t act);
		if (act !== exp)
			fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_led(input string name, input soc_pkg::led_t exp,
		input soc_pkg::led_t act);
		if (act !== exp)
			fail_run($sformatf("Error: %s led expected %h actual %h", name, exp, act));
	endtask

	task automatic check_status(input string name, input soc_pkg::loader_status_t exp,
		input soc_pkg::loader_status_t act);
		if (act !== exp)
			fail_run($sformatf("Error: %s loader status expected %h actual %h",
				name, exp, act));
	endtask

	// expected read value for any address
	function automatic soc_pkg::bus_word_t expected_read(input logic [31:0] addr);
		logic [31:0] region;
		region = addr & soc_pkg::REGION_MASK;
		if (!addr[soc_pkg::MMIO_BIT])
			return main_model[addr[soc_pkg::MAIN_DEPTH_LOG2+1:2]];
		if (region == soc_pkg::SCRATCH_BASE)
			return scratch_model[addr[soc_pkg::SCRATCH_DEPTH_LOG2+1:2]];
		if (region == soc_pkg::GPIO_BASE) begin
			if (addr[3:2] == 2'd0)
				return soc_pkg::bus_word_t'(led_model);
			if (addr[3:2] == 2'd1)
				return soc_pkg::bus_word_t'({sw_model, btn_model});
			return '0;
		end
		if (region == soc_pkg::LOADER_BASE)
			return soc_pkg::bus_word_t'(status_model);
		return '0;
	endfunction

	function automatic void model_write(input logic [31:0] addr, input soc_pkg::bus_word_t data);
		logic [31:0] region;
		region = addr & soc_pkg::REGION_MASK;
		if (!addr[soc_pkg::MMIO_BIT])
			main_model[addr[soc_pkg::MAIN_DEPTH_LOG2+1:2]] = data;
		else if (region == soc_pkg::SCRATCH_BASE)
			scratch_model[addr[soc_pkg::SCRATCH_DEPTH_LOG2+1:2]] = data;
		else if (region == soc_pkg::GPIO_BASE && addr[3:2] == 2'd0)
			led_model = data[soc_pkg::LED_W-1:0];
	endfunction

	// every ready on the processor port against the outstanding access
	always @(negedge clk_mem) begin
		if (cpu_rsp.ready === 1'b1) begin
			if (!pend_active)
				fail_run("a ready pulse arrived with no access outstanding");
			else if (pend_read && pend_check) begin
				if ((pend_addr & soc_pkg::REGION_MASK) == soc_pkg::LOADER_BASE)
					check_status(test_name, soc_pkg::loader_status_t'(pend_exp),
						soc_pkg::loader_status_t'(cpu_rsp.rdata));
				else
					check_word(test_name, pend_exp, cpu_rsp.rdata);
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_mem);
		fail_run($sformatf("the run timed out after %0d cycles", TIMEOUT_CYCLES));
	end

	task automatic acquire(input bit check_latency);
		int waited;
		@(posedge clk_mem);
		#DRIVE_DELAY;
		cpu_req_on = 1'b1;
		waited = 0;
		do begin
			@(posedge clk_mem);
			@(negedge clk_mem);
			waited++;
			if (waited > 50)
				fail_run("the processor port was never granted the bus");
		end while (cpu_gnt !== 1'b1);
		if (check_latency && waited != 1)
			fail_run($sformatf("grant came %0d cycles after request on an idle bus", waited));
	endtask

	task automatic release_bus();
		@(posedge clk_mem);
		#DRIVE_DELAY;
		cpu_req_on = 1'b0;
	endtask

	// one strobe with its ready due exactly one cycle later
	task automatic access(input logic [31:0] addr, input soc_pkg::bus_word_t wdata,
		input bit write, input bit check, output soc_pkg::bus_word_t rdata);
		@(posedge clk_mem);
		#DRIVE_DELAY;
		pend_addr = addr;
		pend_read = !write;
		pend_check = check;
		pend_exp = write ? '0 : expected_read(addr);
		pend_active = 1'b1;
		cpu_bus = '{addr: addr, wdata: wdata, we: write, rd: !write};
		@(posedge clk_mem);
		#DRIVE_DELAY;
		cpu_bus.we = 1'b0;
		cpu_bus.rd = 1'b0;
		@(negedge clk_mem);
		if (cpu_rsp.ready !== 1'b1)
			fail_run("ready did not arrive one cycle after the strobe");
		rdata = cpu_rsp.rdata;
		if (write)
			model_write(addr, wdata);
		@(posedge clk_mem);
		#DRIVE_DELAY;
		pend_active = 1'b0;
	endtask

	task automatic send_byte(input logic [7:0] value);
		@(posedge clk_mem);
		#DRIVE_DELAY;
		rx_data = value;
		rx_new = 1'b1;
		@(posedge clk_mem);
		#DRIVE_DELAY;
		rx_new = 1'b0;
		repeat (10) @(posedge clk_mem);
	endtask

	task automatic send_word(input soc_pkg::bus_word_t value);
		for (int i = 0; i < 4; i++)
			send_byte(value[8*i +: 8]);
	endtask

	// poll the loader status until the given number of words is written
	task automatic wait_loader_count(input int target);
		soc_pkg::loader_status_t st;
		soc_pkg::bus_word_t raw;
		int polls;
		st = '0;
		polls = 0;
		while (int'(st.count) < target) begin
			if (polls == 40)
				fail_run("the loader did not finish its writes");
			polls++;
			repeat (3) @(posedge clk_mem);
			acquire(1'b0);
			access(soc_pkg::LOADER_BASE, '0, 1'b0, 1'b0, raw);
			release_bus();
			st = soc_pkg::loader_status_t'(raw);
		end
	endtask

	task automatic reset_dut();
		@(posedge clk_mem);
		#DRIVE_DELAY;
		rst_n = 1'b0;
		repeat (2) @(posedge clk_mem);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		status_model = '0;
		led_model = '0;
		@(negedge clk_mem);
		if (cpu_gnt !== 1'b0 || cpu_rsp.ready !== 1'b0)
			fail_run("grant or ready is high after reset");
		check_led(test_name, '0, led);
	endtask

	task automatic test_main_memory();
		logic [soc_pkg::MAIN_DEPTH_LOG2-1:0] idx;
		soc_pkg::bus_word_t raw;
		int written_idx[$];
		test_name = "main memory";
		acquire(1'b1);
		// loader status is all zero out of reset
		access(soc_pkg::LOADER_BASE, '0, 1'b0, 1'b1, raw);
		for (int i = 0; i < 24; i++) begin
			idx = soc_pkg::MAIN_DEPTH_LOG2'($random(seed));
			access(32'({idx, 2'b00}), $random(seed), 1'b1, 1'b1, raw);
			written_idx.push_back(int'(idx));
		end
		foreach (written_idx[i])
			access(32'({written_idx[i][soc_pkg::MAIN_DEPTH_LOG2-1:0], 2'b00}), '0,
				1'b0, 1'b1, raw);
		release_bus();
	endtask

	task automatic test_scratch();
		logic [soc_pkg::SCRATCH_DEPTH_LOG2-1:0] idx;
		soc_pkg::bus_word_t raw;
		test_name = "scratch ram";
		acquire(1'b1);
		for (int i = 0; i < 8; i++) begin
			idx = soc_pkg::SCRATCH_DEPTH_LOG2'(i * 5);
			access(32'({idx, 2'b00}), $random(seed), 1'b1, 1'b1, raw);
			access(soc_pkg::SCRATCH_BASE | 32'({idx, 2'b00}), $random(seed), 1'b1, 1'b1, raw);
		end
		// main words at the same low bits must be untouched
		for (int i = 0; i < 8; i++) begin
			idx = soc_pkg::SCRATCH_DEPTH_LOG2'(i * 5);
			access(soc_pkg::SCRATCH_BASE | 32'({idx, 2'b00}), '0, 1'b0, 1'b1, raw);
			access(32'({idx, 2'b00}), '0, 1'b0, 1'b1, raw);
		end
		access(UNMAPPED_ADDR, '0, 1'b0, 1'b1, raw);
		release_bus();
	endtask

	task automatic test_gpio();
		soc_pkg::bus_word_t raw;
		test_name = "gpio";
		acquire(1'b1);
		access(soc_pkg::GPIO_BASE, $random(seed), 1'b1, 1'b1, raw);
		check_led(test_name, led_model, led);
		access(soc_pkg::GPIO_BASE, '0, 1'b0, 1'b1, raw);
		for (int i = 0; i < 3; i++) begin
			@(posedge clk_mem);
			#DRIVE_DELAY;
			sw = soc_pkg::SW_W'($random(seed));
			btn = soc_pkg::BTN_W'($random(seed));
			sw_model = sw;
			btn_model = btn;
			// let the two-flop synchronizer settle
			repeat (3) @(posedge clk_mem);
			access(soc_pkg::GPIO_BASE + 32'd4, '0, 1'b0, 1'b1, raw);
		end
		release_bus();
	endtask

	task automatic test_serial_load();
		soc_pkg::bus_word_t value;
		soc_pkg::bus_word_t raw;
		test_name = "serial loading";
		send_word(soc_pkg::bus_word_t'(LOAD_WORDS));
		for (int k = 0; k < LOAD_WORDS; k++) begin
			value = $random(seed);
			send_word(value);
			main_model[k] = value;
		end
		wait_loader_count(LOAD_WORDS);
		status_model = '{overrun: 1'b0, done: 1'b1, spare: '0, count: 16'(LOAD_WORDS)};
		acquire(1'b1);
		access(soc_pkg::LOADER_BASE, '0, 1'b0, 1'b1, raw);
		for (int k = 0; k < LOAD_WORDS; k++)
			access(32'(4 * k), '0, 1'b0, 1'b1, raw);
		release_bus();
	endtask

	task automatic test_back_pressure();
		soc_pkg::bus_word_t word_a;
		soc_pkg::bus_word_t word_b;
		soc_pkg::bus_word_t raw;
		test_name = "back-pressure";
		// reset while the processor port holds the bus
		acquire(1'b1);
		reset_dut();
		release_bus();
		word_a = $random(seed);
		word_b = $random(seed);
		// word 0 completes while the processor port holds the bus
		acquire(1'b1);
		send_word(32'd3);
		send_word(word_a);
		access(soc_pkg::LOADER_BASE, '0, 1'b0, 1'b1, raw);
		release_bus();
		wait_loader_count(1);
		main_model[0] = word_a;
		status_model.count = 16'd1;
		// word 1 is buffered and word 2 is dropped
		acquire(1'b1);
		send_word(word_b);
		send_word($random(seed));
		status_model.overrun = 1'b1;
		access(soc_pkg::LOADER_BASE, '0, 1'b0, 1'b1, raw);
		release_bus();
		wait_loader_count(2);
		main_model[1] = word_b;
		status_model = '{overrun: 1'b1, done: 1'b1, spare: '0, count: 16'd2};
		acquire(1'b1);
		access(soc_pkg::LOADER_BASE, '0, 1'b0, 1'b1, raw);
		for (int k = 0; k < 3; k++)
			access(32'(4 * k), '0, 1'b0, 1'b1, raw);
		release_bus();
	endtask

	initial begin
		seed = 32'h4d50;
		rst_n = 1'b0;
		cpu_req_on = 1'b0;
		cpu_bus = '0;
		rx_data = '0;
		rx_new = 1'b0;
		sw = '0;
		btn = '0;
		pend_active = 1'b0;
		pend_read = 1'b0;
		pend_check = 1'b0;
		pend_addr = '0;
		pend_exp = '0;
		led_model = '0;
		sw_model = '0;
		btn_model = '0;
		status_model = '0;
		test_name = "reset";
		repeat (2) @(posedge clk_mem);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		test_main_memory();
		test_scratch();
		test_gpio();
		test_serial_load();
		test_back_pressure();
		repeat (5) @(posedge clk_mem);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- src.f
src/soc_pkg.sv
src/word_ram.sv
src/bus_arbiter.sv
src/serial_loader.sv
src/address_decoder.sv
src/gpio_port.sv
src/soc_top.sv
tb/tb_soc.sv

//--- run.sh
#!/bin/sh
# build and run the soc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_soc -f src.f -o tb_soc

./obj_dir/tb_soc
